/* src/gomoku_pkg.sv */
package gomoku_pkg;

    // ==============================
    // Encodings
    // ==============================
    typedef enum logic [1:0] {
        CELL_EMPTY = 2'd0,
        CELL_BLACK = 2'd1,
        CELL_WHITE = 2'd2,
        CELL_EDGE  = 2'd3     // Only seen below the last row.
    } cell_t;

    // Listed in match priority. Value minus one selects the weight.
    typedef enum logic [2:0] {
        SHAPE_NONE          = 3'd0,
        SHAPE_FIVE          = 3'd1,
        SHAPE_OPEN_FOUR     = 3'd2,
        SHAPE_BLOCKED_FOUR  = 3'd3,
        SHAPE_OPEN_THREE    = 3'd4,
        SHAPE_BLOCKED_THREE = 3'd5,
        SHAPE_OPEN_TWO      = 3'd6
    } shape_t;

    typedef enum logic [1:0] {
        SCAN_IDLE  = 2'd0,
        SCAN_CLEAR = 2'd1,
        SCAN_RUN   = 2'd2,
        SCAN_DONE  = 2'd3
    } scan_state_t;

    // ==============================
    // Widths
    // ==============================
    localparam int WIN_LEN    = 6;
    localparam int NUM_SHAPES = 6;
    localparam int WEIGHT_W   = 24;
    localparam int SCORE_W    = 32;
    localparam int DAT_W      = 32;
    localparam int ADR_W      = 10;

    // Word addresses.
    localparam logic [ADR_W-1:0] REG_CTRL        = 10'd0;
    localparam logic [ADR_W-1:0] REG_STATUS      = 10'd1;
    localparam logic [ADR_W-1:0] REG_SCORE       = 10'd2;
    localparam logic [ADR_W-1:0] REG_WEIGHT_BASE = 10'd4;
    localparam logic [ADR_W-1:0] REG_BOARD_BASE  = 10'd256;

    // Element 0 is the five weight, element 5 the open two.
    localparam logic [NUM_SHAPES-1:0][WEIGHT_W-1:0] DEFAULT_WEIGHTS = {
        24'd100,
        24'd100,
        24'd1000,
        24'd10000,
        24'd100000,
        24'd1000000
    };

endpackage

/* src/eval_regs.sv */
`timescale 1ns/100ps

module eval_regs (
    input  logic                                   i_clk,
    input  logic                                   i_rst_n,
    input  logic                                   i_wb_cyc,
    input  logic                                   i_wb_stb,
    input  logic                                   i_wb_we,
    input  logic [gomoku_pkg::ADR_W-1:0]           i_wb_adr,
    input  logic [gomoku_pkg::DAT_W-1:0]           i_wb_dat,
    output logic [gomoku_pkg::DAT_W-1:0]           o_wb_dat,
    output logic                                   o_wb_ack,
    input  logic                                   i_busy,
    input  logic                                   i_done,
    input  logic signed [gomoku_pkg::SCORE_W-1:0]  i_score,
    output logic                                   o_start,
    output logic                                   o_cell_we,
    output logic [7:0]                             o_cell_idx,
    output gomoku_pkg::cell_t                      o_cell_val,
    output logic [gomoku_pkg::NUM_SHAPES-1:0][gomoku_pkg::WEIGHT_W-1:0] o_weights,
    output logic                                   o_eval_done
);

    logic [gomoku_pkg::NUM_SHAPES-1:0][gomoku_pkg::WEIGHT_W-1:0] weights_r;
    logic                          ack_r;
    logic                          start_r;
    logic                          done_r;
    logic [gomoku_pkg::DAT_W-1:0]  rdat_r, rdat_w;
    logic [gomoku_pkg::ADR_W-1:0]  weight_off;
    logic                          req;
    logic                          blocked;
    logic                          is_weight;
    logic                          is_board;

    assign req       = i_wb_cyc && i_wb_stb && !ack_r;   // New request, not yet acked.
    assign blocked   = i_busy || start_r;
    assign weight_off = i_wb_adr - gomoku_pkg::REG_WEIGHT_BASE;
    assign is_weight = (weight_off < gomoku_pkg::ADR_W'(gomoku_pkg::NUM_SHAPES));
    assign is_board  = (i_wb_adr[gomoku_pkg::ADR_W-1:8] ==
                        gomoku_pkg::REG_BOARD_BASE[gomoku_pkg::ADR_W-1:8]);

    // Board writes go straight to the store.
    assign o_cell_we  = req && i_wb_we && is_board && !blocked;
    assign o_cell_idx = i_wb_adr[7:0];
    assign o_cell_val = (i_wb_dat[1:0] == gomoku_pkg::CELL_EDGE) ? gomoku_pkg::CELL_EMPTY
                                                                 : gomoku_pkg::cell_t'(i_wb_dat[1:0]);

    // ==============================
    // Read mux
    // ==============================
    always_comb begin
        rdat_w = '0;
        if (i_wb_adr == gomoku_pkg::REG_STATUS) begin
            rdat_w = {{(gomoku_pkg::DAT_W-2){1'b0}}, done_r, blocked};
        end else if (i_wb_adr == gomoku_pkg::REG_SCORE) begin
            rdat_w = gomoku_pkg::DAT_W'(i_score);
        end else if (is_weight) begin
            rdat_w = gomoku_pkg::DAT_W'(weights_r[weight_off[2:0]]);
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ack_r     <= 1'b0;
            start_r   <= 1'b0;
            done_r    <= 1'b0;
            weights_r <= gomoku_pkg::DEFAULT_WEIGHTS;
        end else begin
            ack_r   <= req;
            start_r <= req && i_wb_we && (i_wb_adr == gomoku_pkg::REG_CTRL)
                       && i_wb_dat[0] && !blocked;
            if (start_r) begin
                done_r <= 1'b0;
            end else if (i_done) begin
                done_r <= 1'b1;
            end
            if (req && i_wb_we && is_weight) begin
                weights_r[weight_off[2:0]] <= i_wb_dat[gomoku_pkg::WEIGHT_W-1:0];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        rdat_r <= rdat_w;   // Only looked at while ack is high.
    end

    assign o_wb_dat    = rdat_r;
    assign o_wb_ack    = ack_r;
    assign o_start     = start_r;
    assign o_weights   = weights_r;
    assign o_eval_done = done_r;

    a_ack_after_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_wb_ack) |-> $past(i_wb_cyc && i_wb_stb));

    a_ack_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb_ack |=> !o_wb_ack);

endmodule

/* src/board_store.sv */
`timescale 1ns/100ps

module board_store #(
    parameter int BOARD_SIZE = 15
) (
    input  logic                                        i_clk,
    input  logic                                        i_rst_n,
    input  logic                                        i_cell_we,
    input  logic [7:0]                                  i_cell_idx,
    input  gomoku_pkg::cell_t                           i_cell_val,
    input  logic [$clog2(BOARD_SIZE)-1:0]               i_row,
    input  logic [$clog2(BOARD_SIZE)-1:0]               i_col,
    output gomoku_pkg::cell_t [gomoku_pkg::WIN_LEN-1:0] o_window
);

    localparam int CELLS = BOARD_SIZE * BOARD_SIZE;

    gomoku_pkg::cell_t cells_r [CELLS];

    // Row major, index = row * BOARD_SIZE + col.
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < CELLS; i++) begin
                cells_r[i] <= gomoku_pkg::CELL_EMPTY;
            end
        end else if (i_cell_we && (int'(i_cell_idx) < CELLS)) begin
            cells_r[i_cell_idx] <= i_cell_val;   // Out of range index dropped.
        end
    end

    // ==============================
    // Column window
    // ==============================
    always_comb begin
        int r;
        for (int i = 0; i < gomoku_pkg::WIN_LEN; i++) begin
            r = int'(i_row) + i;
            if (r < BOARD_SIZE) begin
                o_window[i] = cells_r[r * BOARD_SIZE + int'(i_col)];
            end else begin
                o_window[i] = gomoku_pkg::CELL_EDGE;   // Below the board.
            end
        end
    end

endmodule

/* src/pattern_scanner.sv */
`timescale 1ns/100ps

module pattern_scanner #(
    parameter int BOARD_SIZE = 15
) (
    input  logic                                        i_clk,
    input  logic                                        i_rst_n,
    input  logic                                        i_start,
    input  gomoku_pkg::cell_t [gomoku_pkg::WIN_LEN-1:0] i_window,
    output logic [$clog2(BOARD_SIZE)-1:0]               o_row,
    output logic [$clog2(BOARD_SIZE)-1:0]               o_col,
    output logic                                        o_busy,
    output logic                                        o_done,
    output logic                                        o_clear,
    output logic                                        o_hit_valid,
    output gomoku_pkg::shape_t                          o_black_shape,
    output gomoku_pkg::shape_t                          o_white_shape
);

    localparam int POS_W = $clog2(BOARD_SIZE);
    localparam logic [POS_W-1:0] LAST = POS_W'(BOARD_SIZE - 1);

    gomoku_pkg::scan_state_t state_r, state_w;
    logic [POS_W-1:0] row_r, row_w;
    logic [POS_W-1:0] col_r, col_w;
    gomoku_pkg::cell_t [gomoku_pkg::WIN_LEN-1:0] win_r;
    logic win_valid_r;

    // First matching shape for one colour. Opponent and edge both block.
    function automatic gomoku_pkg::shape_t classify(
        input gomoku_pkg::cell_t [gomoku_pkg::WIN_LEN-1:0] win,
        input gomoku_pkg::cell_t me
    );
        logic [gomoku_pkg::WIN_LEN-1:0] x;
        logic [gomoku_pkg::WIN_LEN-1:0] e;
        logic [gomoku_pkg::WIN_LEN-1:0] o;
        for (int i = 0; i < gomoku_pkg::WIN_LEN; i++) begin
            x[i] = (win[i] == me);
            e[i] = (win[i] == gomoku_pkg::CELL_EMPTY);
            o[i] = !x[i] && !e[i];
        end
        if (&x[4:0]) begin
            return gomoku_pkg::SHAPE_FIVE;
        end
        if (&x[4:1] && e[0] && e[5]) begin
            return gomoku_pkg::SHAPE_OPEN_FOUR;
        end
        if (&x[4:1] && ((e[0] && o[5]) || (o[0] && e[5]))) begin
            return gomoku_pkg::SHAPE_BLOCKED_FOUR;
        end
        if (&x[3:1] && e[0] && e[4]) begin
            return gomoku_pkg::SHAPE_OPEN_THREE;
        end
        if (&x[3:1] && ((e[0] && o[4]) || (o[0] && e[4]))) begin
            return gomoku_pkg::SHAPE_BLOCKED_THREE;
        end
        if (&x[2:1] && e[0] && e[3]) begin
            return gomoku_pkg::SHAPE_OPEN_TWO;
        end
        return gomoku_pkg::SHAPE_NONE;
    endfunction

    // ==============================
    // Scan FSM
    // ==============================
    always_comb begin
        state_w = state_r;
        row_w   = row_r;
        col_w   = col_r;
        case (state_r)
            gomoku_pkg::SCAN_IDLE: begin
                if (i_start) begin
                    state_w = gomoku_pkg::SCAN_CLEAR;
                end
            end
            gomoku_pkg::SCAN_CLEAR: begin
                row_w   = '0;
                col_w   = '0;
                state_w = gomoku_pkg::SCAN_RUN;
            end
            gomoku_pkg::SCAN_RUN: begin
                if (col_r == LAST) begin
                    col_w = '0;
                    if (row_r == LAST) begin
                        row_w   = '0;
                        state_w = gomoku_pkg::SCAN_DONE;
                    end else begin
                        row_w = row_r + 1'b1;
                    end
                end else begin
                    col_w = col_r + 1'b1;
                end
            end
            default: begin
                state_w = gomoku_pkg::SCAN_IDLE;   // Done lasts one cycle.
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_r     <= gomoku_pkg::SCAN_IDLE;
            row_r       <= '0;
            col_r       <= '0;
            win_valid_r <= 1'b0;
        end else begin
            state_r     <= state_w;
            row_r       <= row_w;
            col_r       <= col_w;
            win_valid_r <= (state_r == gomoku_pkg::SCAN_RUN);
        end
    end

    always_ff @(posedge i_clk) begin
        win_r <= i_window;
    end

    assign o_row         = row_r;
    assign o_col         = col_r;
    assign o_busy        = (state_r != gomoku_pkg::SCAN_IDLE);
    assign o_done        = (state_r == gomoku_pkg::SCAN_DONE);
    assign o_clear       = (state_r == gomoku_pkg::SCAN_CLEAR);
    assign o_hit_valid   = win_valid_r;
    assign o_black_shape = classify(win_r, gomoku_pkg::CELL_BLACK);
    assign o_white_shape = classify(win_r, gomoku_pkg::CELL_WHITE);

    a_hit_in_run: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_hit_valid |-> (state_r == gomoku_pkg::SCAN_RUN || state_r == gomoku_pkg::SCAN_DONE));

endmodule

/* src/score_accum.sv */
`timescale 1ns/100ps

module score_accum (
    input  logic                                   i_clk,
    input  logic                                   i_rst_n,
    input  logic                                   i_clear,
    input  logic                                   i_hit_valid,
    input  gomoku_pkg::shape_t                     i_black_shape,
    input  gomoku_pkg::shape_t                     i_white_shape,
    input  logic [gomoku_pkg::NUM_SHAPES-1:0][gomoku_pkg::WEIGHT_W-1:0] i_weights,
    output logic signed [gomoku_pkg::SCORE_W-1:0]  o_score
);

    logic signed [gomoku_pkg::SCORE_W-1:0] score_r;
    logic signed [gomoku_pkg::SCORE_W-1:0] black_w;
    logic signed [gomoku_pkg::SCORE_W-1:0] white_w;

    // No shape adds nothing.
    function automatic logic signed [gomoku_pkg::SCORE_W-1:0] weight_of(
        input gomoku_pkg::shape_t shape,
        input logic [gomoku_pkg::NUM_SHAPES-1:0][gomoku_pkg::WEIGHT_W-1:0] weights
    );
        if (shape == gomoku_pkg::SHAPE_NONE) begin
            return '0;
        end
        return $signed({{(gomoku_pkg::SCORE_W-gomoku_pkg::WEIGHT_W){1'b0}},
                        weights[int'(shape) - 1]});
    endfunction

    assign black_w = weight_of(i_black_shape, i_weights);
    assign white_w = weight_of(i_white_shape, i_weights);

    // ==============================
    // Running total
    // ==============================
    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_clear) begin
            score_r <= '0;
        end else if (i_hit_valid) begin
            score_r <= score_r + black_w - white_w;   // Black minus white.
        end
    end

    assign o_score = score_r;

    // The scanner never clears in the middle of a scan.
    a_no_clear_on_hit: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_clear && i_hit_valid));

endmodule

/* src/gomoku_eval.sv */
`timescale 1ns/100ps

module gomoku_eval #(
    parameter int BOARD_SIZE = 15
) (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_wb_cyc,
    input  logic                          i_wb_stb,
    input  logic                          i_wb_we,
    input  logic [gomoku_pkg::ADR_W-1:0]  i_wb_adr,
    input  logic [gomoku_pkg::DAT_W-1:0]  i_wb_dat,
    output logic [gomoku_pkg::DAT_W-1:0]  o_wb_dat,
    output logic                          o_wb_ack,
    output logic                          o_eval_done
);

    localparam int POS_W = $clog2(BOARD_SIZE);

    logic                                        start;
    logic                                        cell_we;
    logic [7:0]                                  cell_idx;
    gomoku_pkg::cell_t                           cell_val;
    logic [POS_W-1:0]                            row;
    logic [POS_W-1:0]                            col;
    gomoku_pkg::cell_t [gomoku_pkg::WIN_LEN-1:0] window;
    logic                                        busy;
    logic                                        done;
    logic                                        clear;
    logic                                        hit_valid;
    gomoku_pkg::shape_t                          black_shape;
    gomoku_pkg::shape_t                          white_shape;
    logic [gomoku_pkg::NUM_SHAPES-1:0][gomoku_pkg::WEIGHT_W-1:0] weights;
    logic signed [gomoku_pkg::SCORE_W-1:0]       score;

    eval_regs i_eval_regs (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wb_cyc    (i_wb_cyc),
        .i_wb_stb    (i_wb_stb),
        .i_wb_we     (i_wb_we),
        .i_wb_adr    (i_wb_adr),
        .i_wb_dat    (i_wb_dat),
        .o_wb_dat    (o_wb_dat),
        .o_wb_ack    (o_wb_ack),
        .i_busy      (busy),
        .i_done      (done),
        .i_score     (score),
        .o_start     (start),
        .o_cell_we   (cell_we),
        .o_cell_idx  (cell_idx),
        .o_cell_val  (cell_val),
        .o_weights   (weights),
        .o_eval_done (o_eval_done)
    );

    board_store #(.BOARD_SIZE(BOARD_SIZE)) i_board_store (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_cell_we  (cell_we),
        .i_cell_idx (cell_idx),
        .i_cell_val (cell_val),
        .i_row      (row),
        .i_col      (col),
        .o_window   (window)
    );

    pattern_scanner #(.BOARD_SIZE(BOARD_SIZE)) i_pattern_scanner (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_start       (start),
        .i_window      (window),
        .o_row         (row),
        .o_col         (col),
        .o_busy        (busy),
        .o_done        (done),
        .o_clear       (clear),
        .o_hit_valid   (hit_valid),
        .o_black_shape (black_shape),
        .o_white_shape (white_shape)
    );

    score_accum i_score_accum (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_clear       (clear),
        .i_hit_valid   (hit_valid),
        .i_black_shape (black_shape),
        .i_white_shape (white_shape),
        .i_weights     (weights),
        .o_score       (score)
    );

endmodule

/* verification/tb_gomoku_eval.sv */
`timescale 1ns/100ps

module tb_gomoku_eval;

    localparam int BOARD_SIZE = 15;

    logic                         i_clk;
    logic                         i_rst_n;
    logic                         i_wb_cyc;
    logic                         i_wb_stb;
    logic                         i_wb_we;
    logic [gomoku_pkg::ADR_W-1:0] i_wb_adr;
    logic [gomoku_pkg::DAT_W-1:0] i_wb_dat;
    logic [gomoku_pkg::DAT_W-1:0] o_wb_dat;
    logic                         o_wb_ack;
    logic                         o_eval_done;

    string lines[$];
    int    error_count = 0;
    int    cycle_count = 0;
    int    cycle_limit = 1000;   // Raised once the data file is read.
    int    done_rises  = 0;
    int    rises_seen  = 0;
    logic  done_q      = 1'b0;

    gomoku_eval #(.BOARD_SIZE(BOARD_SIZE)) i_gomoku_eval (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wb_cyc    (i_wb_cyc),
        .i_wb_stb    (i_wb_stb),
        .i_wb_we     (i_wb_we),
        .i_wb_adr    (i_wb_adr),
        .i_wb_dat    (i_wb_dat),
        .o_wb_dat    (o_wb_dat),
        .o_wb_ack    (o_wb_ack),
        .o_eval_done (o_eval_done)
    );

    always #2 i_clk = ~i_clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "Run stopped at the first error.");
    endtask

    // Cycle limit and count of done edges.
    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        done_q      <= o_eval_done;
        if (o_eval_done && !done_q) begin
            done_rises <= done_rises + 1;
        end
        if (cycle_count > cycle_limit) begin
            abort_run($sformatf("Timeout: the run did not end within %0d cycles.", cycle_limit));
        end
    end

    // ==============================
    // Checks
    // ==============================
    task automatic check_word(input string name, input logic [gomoku_pkg::DAT_W-1:0] got,
                              input logic [gomoku_pkg::DAT_W-1:0] exp);
        if (got !== exp) begin
            error_count++;
            abort_run($sformatf("FAILED at %0d ns: %s is 0x%08h, expected 0x%08h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_score(input string name,
                               input logic signed [gomoku_pkg::SCORE_W-1:0] got,
                               input logic signed [gomoku_pkg::SCORE_W-1:0] exp);
        if (got !== exp) begin
            error_count++;
            abort_run($sformatf("FAILED at %0d ns: %s is %0d, expected %0d",
                                $time, name, got, exp));
        end
    endtask

    // ==============================
    // Wishbone master
    // ==============================
    task automatic wb_transfer(input logic we, input logic [gomoku_pkg::ADR_W-1:0] adr,
                               input logic [gomoku_pkg::DAT_W-1:0] dat,
                               output logic [gomoku_pkg::DAT_W-1:0] rdat);
        logic ack_seen;
        @(posedge i_clk);
        #1;
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = we;
        i_wb_adr = adr;
        i_wb_dat = dat;
        ack_seen = 1'b0;
        while (!ack_seen) begin
            @(posedge i_clk);
            #1;
            ack_seen = o_wb_ack;
        end
        rdat     = o_wb_dat;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
    endtask

    // Start, then poll status until done.
    task automatic run_scan();
        logic [gomoku_pkg::DAT_W-1:0] rdat;
        logic [gomoku_pkg::DAT_W-1:0] status;
        wb_transfer(1'b1, gomoku_pkg::REG_CTRL, 32'd1, rdat);
        status = '0;
        while (status[1] !== 1'b1) begin
            wb_transfer(1'b0, gomoku_pkg::REG_STATUS, '0, status);
        end
        check_word("status after scan", status, 32'h2);
        check_word("o_eval_done rises per scan", 32'(done_rises - rises_seen), 32'd1);
        rises_seen = done_rises;
    endtask

    initial begin
        int                           fd;
        int                           fields;
        int                           n_scans;
        string                        line;
        logic [7:0]                   cmd;
        logic [gomoku_pkg::ADR_W-1:0] adr;
        logic [gomoku_pkg::DAT_W-1:0] dat;
        logic [gomoku_pkg::DAT_W-1:0] rdat;
        i_clk    = 1'b0;
        i_rst_n  = 1'b0;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
        i_wb_adr = '0;
        i_wb_dat = '0;
        n_scans  = 0;
        fd = $fopen("verification/eval_input.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open verification/eval_input.txt for reading.");
        end
        while (!$feof(fd)) begin
            line = "";
            fields = $fgets(line, fd);
            if (fields > 0 && line.len() > 1 && line[0] != "#") begin
                lines.push_back(line);
                if (line[0] == "P") begin
                    n_scans++;
                end
            end
        end
        $fclose(fd);
        cycle_limit = 20 * n_scans * BOARD_SIZE * BOARD_SIZE + 100;

        repeat (3) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        check_word("o_wb_ack after reset", 32'(o_wb_ack), 32'd0);
        check_word("o_eval_done after reset", 32'(o_eval_done), 32'd0);

        foreach (lines[i]) begin
            fields = $sscanf(lines[i], "%c %h %h", cmd, adr, dat);
            if ((cmd == "W" || cmd == "R") && fields < 3) begin
                abort_run($sformatf("Malformed line in data file: %s", lines[i]));
            end
            case (cmd)
                "W": begin
                    wb_transfer(1'b1, adr, dat, rdat);
                end
                "R": begin
                    wb_transfer(1'b0, adr, '0, rdat);
                    if (adr == gomoku_pkg::REG_SCORE) begin
                        check_score("score o_wb_dat", $signed(rdat), $signed(dat));
                    end else begin
                        check_word($sformatf("o_wb_dat at 0x%03h", adr), rdat, dat);
                    end
                end
                "P": begin
                    run_scan();
                end
                default: begin
                    abort_run($sformatf("Unknown command in data file: %s", lines[i]));
                end
            endcase
        end

        if (error_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            abort_run("Errors were counted during the run.");
        end
    end

endmodule

/* verification/eval_input.txt */
# Columns: command, word address (hex), data or expected value (hex, 32-bit two's complement).
# W writes, R reads and compares, P starts a scan and waits. Cells sit at 0x100 + row*15 + col.
R 001 00000000
R 004 000F4240
R 005 000186A0
R 006 00002710
R 007 000003E8
R 008 00000064
R 009 00000064
R 002 00000000
# Vertical black five in column 7, rows 5 to 9
W 152 1
W 161 1
W 170 1
W 17F 1
W 18E 1
P
R 002 000F4240
# Row 9 cleared leaves an open four
W 18E 0
P
R 002 000186A0
# White stone below blocks it, the lone white stone has no shape
W 18E 2
P
R 002 00002710
# Second black four in column 0, rows 11 to 14, blocked by the lower edge
W 1A5 1
W 1B4 1
W 1C3 1
W 1D2 1
P
R 002 00004E20
# Black open two against white open two and open three gives -1000
W 152 0
W 17F 0
W 19D 2
W 1A5 2
W 1B4 2
W 1C3 2
W 1D2 0
P
R 002 FFFFFC18
# Open three weight 50 and open two weight 7 give -50
W 007 32
W 009 7
R 007 00000032
R 009 00000007
P
R 002 FFFFFFCE
# Board write and second start while busy are ignored
W 000 1
W 17F 1
W 000 1
P
R 002 FFFFFFCE
R 001 00000002
P
R 002 FFFFFFCE

/* gomoku_eval.f */
src/gomoku_pkg.sv
src/eval_regs.sv
src/board_store.sv
src/pattern_scanner.sv
src/score_accum.sv
src/gomoku_eval.sv
verification/tb_gomoku_eval.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_gomoku_eval \
		-f gomoku_eval.f -Mdir obj_dir
	./obj_dir/Vtb_gomoku_eval | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf obj_dir
